// File: src/pcs_tx_pkg.sv
/*
 * Transmit PCS shared definitions
 * Line code widths, MAC control characters and 64b/66b block type bytes
 */
`default_nettype none

package pcs_tx_pkg;

    localparam int word_w       = 32;
    localparam int payload_w    = 64;
    localparam int block_w      = 66;
    localparam int res_w        = block_w + word_w - 1;  // Worst case gearbox residue
    localparam int pause_period = 33;                    // txc cycles per pause cycle
    localparam int scr_len      = 58;                    // x^58 + x^39 + 1

    // MAC control characters
    localparam logic [7:0] ctl_idle  = 8'h07;
    localparam logic [7:0] ctl_start = 8'hfb;
    localparam logic [7:0] ctl_term  = 8'hfd;
    localparam logic [7:0] ctl_error = 8'hfe;

    // Block type bytes sent in payload byte 0 of a control block
    localparam logic [7:0] type_idle   = 8'h1e;
    localparam logic [7:0] type_start0 = 8'h78;
    localparam logic [7:0] type_start4 = 8'h33;
    localparam logic [7:0] type_term0  = 8'h87;
    localparam logic [7:0] type_term1  = 8'h99;
    localparam logic [7:0] type_term2  = 8'haa;
    localparam logic [7:0] type_term3  = 8'hb4;
    localparam logic [7:0] type_term4  = 8'hcc;
    localparam logic [7:0] type_term5  = 8'hd2;
    localparam logic [7:0] type_term6  = 8'he1;
    localparam logic [7:0] type_term7  = 8'hff;

    localparam logic [1:0] sync_data = 2'b01;
    localparam logic [1:0] sync_ctl  = 2'b10;

    // The encoder indexes terminate kinds by lane and relies on their order
    typedef enum logic [3:0] {
        blk_data,
        blk_idle,
        blk_start0,
        blk_start4,
        blk_term0,
        blk_term1,
        blk_term2,
        blk_term3,
        blk_term4,
        blk_term5,
        blk_term6,
        blk_term7,
        blk_error
    } block_kind_e;

endpackage

`default_nettype wire

// File: src/xgmii_encoder.sv
/*
 * XGMII to 64b/66b encoder
 * Pairs accepted 32-bit MAC words and classifies each pair into one 66-bit block
 */
`default_nettype none

module xgmii_encoder
    import pcs_tx_pkg::*;
(
    input  wire                txc,
    input  wire                reset,
    input  wire [word_w-1:0]   txd,
    input  wire [3:0]          txctl,
    input  wire                tx_pause,
    output logic [block_w-1:0] enc_block,
    output logic               enc_valid
);

    logic                 accept;
    logic                 second;        // Next accepted word completes a pair
    logic [word_w-1:0]    first_txd;
    logic [3:0]           first_txctl;
    logic [payload_w-1:0] d64;
    logic [7:0]           ctl8;
    logic [payload_w-1:0] masked;
    block_kind_e          kind;
    logic [1:0]           header;
    logic [payload_w-1:0] payload;

    // Control bytes expected for a terminate in lane n
    function automatic logic [payload_w-1:0] term_pattern(input int n);
        logic [payload_w-1:0] p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (i == n) begin
                p[8*i +: 8] = ctl_term;
            end else if (i > n) begin
                p[8*i +: 8] = ctl_idle;
            end
        end
        return p;
    endfunction

    function automatic logic [7:0] term_type(input int n);
        case (n)
            0:       return type_term0;
            1:       return type_term1;
            2:       return type_term2;
            3:       return type_term3;
            4:       return type_term4;
            5:       return type_term5;
            6:       return type_term6;
            default: return type_term7;
        endcase
    endfunction

    assign accept = !tx_pause;
    assign d64    = {txd, first_txd};     // First word lands in bytes 0..3
    assign ctl8   = {txctl, first_txctl};

    // Zero the data lanes so only control characters take part in matching
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            masked[8*i +: 8] = ctl8[i] ? d64[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        kind = blk_error;
        if (ctl8 == 8'h00) begin
            kind = blk_data;
        end else if (ctl8 == 8'hff && masked == {8{ctl_idle}}) begin
            kind = blk_idle;
        end else if (ctl8 == 8'h01 && masked == {56'h0, ctl_start}) begin
            kind = blk_start0;
        end else if (ctl8 == 8'h1f && masked == {24'h0, ctl_start, {4{ctl_idle}}}) begin
            kind = blk_start4;
        end else begin
            // Data below lane n, terminate in lane n, idle above it
            for (int n = 0; n < 8; n++) begin
                if (ctl8 == (8'hff << n) && masked == term_pattern(n)) begin
                    kind = block_kind_e'(int'(blk_term0) + n);
                end
            end
        end
    end

    always_comb begin
        int                   n;
        logic [payload_w-1:0] keep;
        n      = int'(kind) - int'(blk_term0);
        keep   = '1;
        header = sync_ctl;
        case (kind)
            blk_data: begin
                header  = sync_data;
                payload = d64;
            end
            blk_idle:   payload = {56'h0, type_idle};
            blk_start0: payload = {d64[63:8], type_start0};
            blk_start4: payload = {d64[63:40], 32'h0, type_start4};   // Idle lanes sent as zeros
            blk_error:  payload = {8{type_idle}};
            default: begin
                keep    = ~({payload_w{1'b1}} << (8 * (n + 1)));  // Type byte plus n data bytes
                payload = {d64[55:0], term_type(n)} & keep;
            end
        endcase
    end

    always_ff @(posedge txc) begin
        if (reset) begin
            second    <= 1'b0;
            enc_valid <= 1'b0;
        end else begin
            enc_valid <= accept && second;
            if (accept) begin
                second <= !second;
            end
        end
    end

    always_ff @(posedge txc) begin
        if (accept && !second) begin
            first_txd   <= txd;
            first_txctl <= txctl;
        end
        if (accept && second) begin
            enc_block <= {payload, header};
        end
    end

endmodule

`default_nettype wire

// File: src/block_scrambler.sv
/*
 * Self-synchronizing payload scrambler with polynomial x^58 + x^39 + 1
 * Sync header passes through untouched in one register stage
 */
`default_nettype none

module block_scrambler
    import pcs_tx_pkg::*;
(
    input  wire                txc,
    input  wire                reset,
    input  wire [block_w-1:0]  enc_block,
    input  wire                enc_valid,
    output logic [block_w-1:0] scr_block,
    output logic               scr_valid
);

    logic [scr_len-1:0]   state;         // Bit 0 is the most recent output bit
    logic [scr_len-1:0]   state_next;
    logic [payload_w-1:0] scr_payload;

    // Serial scrambling unrolled over the 64 payload bits in LSB order
    always_comb begin
        logic [scr_len-1:0] s;
        logic               b;
        s = state;
        for (int i = 0; i < payload_w; i++) begin
            b              = enc_block[i+2] ^ s[38] ^ s[scr_len-1];
            scr_payload[i] = b;
            s              = {s[scr_len-2:0], b};
        end
        state_next = s;
    end

    always_ff @(posedge txc) begin
        if (reset) begin
            state     <= '1;
            scr_valid <= 1'b0;
        end else begin
            scr_valid <= enc_valid;
            if (enc_valid) begin
                state <= state_next;   // Only advances on real blocks
            end
        end
    end

    always_ff @(posedge txc) begin
        if (enc_valid) begin
            scr_block <= {scr_payload, enc_block[1:0]};
        end
    end

endmodule

`default_nettype wire

// File: src/tx_gearbox.sv
/*
 * 66-bit to 32-bit transmit gearbox
 * Residue buffer for leftover block bits, pause generation once every 33 cycles
 */
`default_nettype none

module tx_gearbox
    import pcs_tx_pkg::*;
(
    input  wire                txc,
    input  wire                reset,
    input  wire [block_w-1:0]  scr_block,
    input  wire                scr_valid,
    output logic               tx_pause,
    output logic [word_w-1:0]  tx_word,
    output logic               tx_word_valid
);

    logic [res_w-1:0] residue;        // Oldest bit in bit 0
    logic [res_w-1:0] rem;
    logic [res_w-1:0] residue_next;
    logic [6:0]       bit_cnt;
    logic [6:0]       rem_cnt;
    logic [6:0]       cnt_next;
    logic [5:0]       cycle_cnt;
    logic             emit;

    assign tx_pause = (cycle_cnt == 6'(pause_period - 1));

    always_comb begin
        emit         = (bit_cnt >= 7'(word_w));
        rem          = emit ? (residue >> word_w) : residue;
        rem_cnt      = emit ? (bit_cnt - 7'(word_w)) : bit_cnt;
        residue_next = rem;
        cnt_next     = rem_cnt;
        if (scr_valid) begin
            // New block goes above whatever is left
            residue_next = rem | (res_w'(scr_block) << rem_cnt);
            cnt_next     = rem_cnt + 7'(block_w);
        end
    end

    always_ff @(posedge txc) begin
        if (reset) begin
            residue       <= '0;
            bit_cnt       <= '0;
            cycle_cnt     <= '0;
            tx_word_valid <= 1'b0;
        end else begin
            residue       <= residue_next;
            bit_cnt       <= cnt_next;
            tx_word_valid <= emit;
            if (tx_pause) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge txc) begin
        if (emit) begin
            tx_word <= residue[word_w-1:0];
        end
    end

endmodule

`default_nettype wire

// File: src/pcs_tx.sv
/*
 * 10GBASE-R style transmit PCS top
 * Encoder, scrambler and gearbox in a chain
 */
`default_nettype none

module pcs_tx
    import pcs_tx_pkg::*;
(
    input  wire                txc,
    input  wire                reset,
    input  wire [word_w-1:0]   txd,
    input  wire [3:0]          txctl,
    output logic               tx_pause,
    output logic [word_w-1:0]  tx_word,
    output logic               tx_word_valid
);

    logic [block_w-1:0] enc_block;
    logic               enc_valid;
    logic [block_w-1:0] scr_block;
    logic               scr_valid;

    xgmii_encoder u_encoder (
        .txc       (txc),
        .reset     (reset),
        .txd       (txd),
        .txctl     (txctl),
        .tx_pause  (tx_pause),
        .enc_block (enc_block),
        .enc_valid (enc_valid)
    );

    block_scrambler u_scrambler (
        .txc       (txc),
        .reset     (reset),
        .enc_block (enc_block),
        .enc_valid (enc_valid),
        .scr_block (scr_block),
        .scr_valid (scr_valid)
    );

    tx_gearbox u_gearbox (
        .txc           (txc),
        .reset         (reset),
        .scr_block     (scr_block),
        .scr_valid     (scr_valid),
        .tx_pause      (tx_pause),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid)
    );

endmodule

`default_nettype wire

// File: verif/pcs_tx_properties.sv
/*
 * Bound checks on pause spacing, encoder strobe and output word valid
 */
`default_nettype none

module pcs_tx_properties
    import pcs_tx_pkg::*;
(
    input wire txc,
    input wire reset,
    input wire tx_pause,
    input wire enc_valid,
    input wire tx_word_valid
);

    int fail_count = 0;

    // One pause cycle then exactly 32 free cycles before the next
    pause_spacing: assert property (@(posedge txc) disable iff (reset)
        tx_pause |=> !tx_pause [*pause_period-1] ##1 tx_pause)
        else begin
            fail_count++;
            $error("tx_pause is not high for one cycle in 33");
        end

    enc_valid_pulse: assert property (@(posedge txc) disable iff (reset)
        enc_valid |=> !enc_valid)
        else begin
            fail_count++;
            $error("enc_valid high on two consecutive cycles");
        end

    word_valid_steady: assert property (@(posedge txc) disable iff (reset)
        tx_word_valid |=> tx_word_valid)
        else begin
            fail_count++;
            $error("tx_word_valid fell after it had risen");
        end

endmodule

bind tx_gearbox pcs_tx_properties u_gearbox_props (
    .txc           (txc),
    .reset         (reset),
    .tx_pause      (tx_pause),
    .enc_valid     (1'b0),
    .tx_word_valid (tx_word_valid)
);

bind xgmii_encoder pcs_tx_properties u_encoder_props (
    .txc           (txc),
    .reset         (reset),
    .tx_pause      (tx_pause),
    .enc_valid     (enc_valid),
    .tx_word_valid (1'b1)
);

`default_nettype wire

// File: verif/pcs_tx_tb.sv
/*
 * Directed testbench for the transmit PCS
 * Reference encoder, descrambler and block reassembly on the gearbox word stream
 */
`default_nettype none

module pcs_tx_tb
    import pcs_tx_pkg::*;
();

    logic               txc = 1'b0;
    logic               reset = 1'b1;
    logic [word_w-1:0]  txd = '0;
    logic [3:0]         txctl = '0;
    logic               tx_pause;
    logic [word_w-1:0]  tx_word;
    logic               tx_word_valid;

    logic [block_w-1:0] exp_q[$];          // Expected blocks before scrambling
    logic [scr_len-1:0] dsc_state = '1;
    logic [127:0]       acc = '0;          // Reassembly bits with the oldest in bit 0
    int                 acc_n = 0;
    int                 pushed = 0;
    int                 checked = 0;
    int                 errors = 0;
    int                 err_mark = 0;
    int                 prop_fails = 0;
    int                 tests = 0;
    int                 failed_tests = 0;
    int                 pauses = 0;
    int                 cycle_no = 0;
    int                 last_pause = -1;

    pcs_tx DUT (
        .txc           (txc),
        .reset         (reset),
        .txd           (txd),
        .txctl         (txctl),
        .tx_pause      (tx_pause),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid)
    );

    always #50 txc = ~txc;

    function automatic logic [63:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    // Expected block from the 64b/66b rule with the header in bits 1:0
    function automatic logic [block_w-1:0] model_block(input logic [63:0] d,
                                                       input logic [7:0]  c);
        logic [7:0]  tt [8];
        logic [63:0] p;
        logic        ok;
        tt = '{type_term0, type_term1, type_term2, type_term3,
               type_term4, type_term5, type_term6, type_term7};
        if (c == 8'h00) return {d, sync_data};
        p = {8{type_idle}};   // Error block unless a pattern matches
        if (c == 8'hff && d == {8{ctl_idle}}) p = {56'h0, type_idle};
        if (c == 8'h01 && d[7:0] == ctl_start) p = {d[63:8], type_start0};
        if (c == 8'h1f && d[39:0] == {ctl_start, {4{ctl_idle}}})
            p = {d[63:40], 32'h0, type_start4};
        for (int n = 0; n < 8; n++) begin
            ok = (c == 8'(8'hff << n)) && (d[8*n +: 8] == ctl_term);
            for (int i = n + 1; i < 8; i++) ok = ok && (d[8*i +: 8] == ctl_idle);
            if (ok) begin
                p = {56'h0, tt[n]};
                for (int i = 0; i < n; i++) p[8*i+8 +: 8] = d[8*i +: 8];
            end
        end
        return {p, sync_ctl};
    endfunction

    // Drive one word and hold it through a pause
    task automatic send_word(input logic [31:0] d, input logic [3:0] c);
        logic held;
        int   t;
        txd   <= d;
        txctl <= c;
        t     = 0;
        do begin
            @(negedge txc);
            held = tx_pause;
            if (held) begin
                if (last_pause >= 0 && cycle_no - last_pause != pause_period) begin
                    $display("MISMATCH time=%0t signal=tx_pause_spacing expected=%0d actual=%0d",
                             $time, pause_period, cycle_no - last_pause);
                    errors++;
                end
                last_pause = cycle_no;
                pauses++;
            end
            @(posedge txc);
            cycle_no++;
            t++;
        end while (held && t < 4);
        if (held) begin
            $display("Word %h was never accepted, tx_pause stayed high", d);
            errors++;
        end
    endtask

    task automatic send_pair(input logic [63:0] d, input logic [7:0] c);
        exp_q.push_back(model_block(d, c));
        pushed++;
        send_word(d[31:0], c[3:0]);
        send_word(d[63:32], c[7:4]);
    endtask

    task automatic check_block(input logic [block_w-1:0] raw);
        logic [payload_w-1:0] pay;
        logic [block_w-1:0]   want;
        for (int i = 0; i < payload_w; i++) begin
            pay[i]    = raw[i+2] ^ dsc_state[38] ^ dsc_state[scr_len-1];
            dsc_state = {dsc_state[scr_len-2:0], raw[i+2]};   // Line bits feed the state
        end
        checked++;
        if (exp_q.size() == 0) begin
            $display("Block %0d came out with no block expected", checked);
            errors++;
        end else begin
            want = exp_q.pop_front();
            if (raw[1:0] != want[1:0]) begin
                $display("MISMATCH time=%0t signal=sync_header expected=%b actual=%b",
                         $time, want[1:0], raw[1:0]);
                errors++;
            end
            if (pay != want[block_w-1:2]) begin
                $display("MISMATCH time=%0t signal=payload expected=%h actual=%h",
                         $time, want[block_w-1:2], pay);
                errors++;
            end
        end
    endtask

    // Blocks every 66 bits from the first valid word
    always @(negedge txc) begin
        if (tx_word_valid) begin
            acc   = acc | (128'(tx_word) << acc_n);
            acc_n = acc_n + word_w;
            if (acc_n >= block_w) begin
                check_block(acc[block_w-1:0]);
                acc   = acc >> block_w;
                acc_n = acc_n - block_w;
            end
        end
    end

    // Idle pairs keep the stream going until every sent block is checked
    task automatic end_test(input string name);
        int target;
        int t;
        int prop_now;
        target = pushed;
        t      = 0;
        while (checked < target && t < 20) begin
            send_pair({8{ctl_idle}}, 8'hff);
            t++;
        end
        if (checked < target) begin
            $display("%s: %0d blocks never came out of the gearbox", name, target - checked);
            errors++;
        end
        prop_now = DUT.u_gearbox.u_gearbox_props.fail_count
                 + DUT.u_encoder.u_encoder_props.fail_count;
        if (prop_now != prop_fails) begin
            $display("%s: %0d bound assertions failed", name, prop_now - prop_fails);
            errors     = errors + prop_now - prop_fails;
            prop_fails = prop_now;
        end
        tests++;
        if (errors == err_mark) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic idle_stream();
        repeat (4) send_pair({8{ctl_idle}}, 8'hff);
        end_test("idle_stream");
    endtask

    task automatic data_blocks();
        repeat (6) send_pair(rnd64(), 8'h00);
        end_test("data_blocks");
    endtask

    task automatic frame_start();
        logic [63:0] d;
        d       = rnd64();
        d[7:0]  = ctl_start;
        send_pair(d, 8'h01);
        d       = rnd64();
        d[39:0] = {ctl_start, {4{ctl_idle}}};
        send_pair(d, 8'h1f);
        end_test("frame_start");
    endtask

    task automatic terminate_lanes();
        logic [63:0] d;
        for (int n = 0; n < 8; n++) begin
            d           = rnd64();
            d[8*n +: 8] = ctl_term;
            for (int i = n + 1; i < 8; i++) d[8*i +: 8] = ctl_idle;
            send_pair(d, 8'(8'hff << n));
        end
        end_test("terminate_lanes");
    endtask

    task automatic invalid_control();
        logic [63:0] d;
        d          = rnd64();
        d[23:16]   = ctl_error;
        send_pair(d, 8'h04);         // Stray error character
        d[23:16]   = ctl_start;
        send_pair(d, 8'h04);         // Start in lane 2
        d[31:24]   = ctl_term;
        send_pair(d, 8'h08);         // Terminate with data after it
        end_test("invalid_control");
    endtask

    task automatic pause_compliance();
        int p0;
        p0 = pauses;
        repeat (50) send_pair(rnd64(), 8'h00);
        if (pauses - p0 < 3) begin
            $display("Only %0d pauses seen over 100 words", pauses - p0);
            errors++;
        end
        end_test("pause_compliance");
    endtask

    initial begin
        void'($urandom(32'ha6e57b9b));
        repeat (10) @(posedge txc);
        reset <= 1'b0;
        idle_stream();
        data_blocks();
        frame_start();
        terminate_lanes();
        invalid_control();
        pause_compliance();
        $display("Tests %0d, failed %0d, errors %0d, blocks checked %0d",
                 tests, failed_tests, errors, checked);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pcs_tx.f
src/pcs_tx_pkg.sv
src/xgmii_encoder.sv
src/block_scrambler.sv
src/tx_gearbox.sv
src/pcs_tx.sv
verif/pcs_tx_properties.sv
verif/pcs_tx_tb.sv

// File: Bender.yml
package:
  name: pcs_tx

sources:
  - src/pcs_tx_pkg.sv
  - src/xgmii_encoder.sv
  - src/block_scrambler.sv
  - src/tx_gearbox.sv
  - src/pcs_tx.sv
  - target: test
    files:
      - verif/pcs_tx_properties.sv
      - verif/pcs_tx_tb.sv
